/* hdl/acsPkg.sv */
`default_nettype none

package acsPkg;

   // sample and metric widths
   localparam int mfBits        = 10;  // matched-filter sample, two's complement
   localparam int rotBits       = 8;   // rotator works on the top bits of each mf sample
   localparam int acsBits       = 10;  // accumulated metric width
   localparam int angleBits     = 5;   // angle counts steps of 2*pi/32
   localparam int rotConstBits  = 4;   // per-branch rotation constant, doubled into an angle
   localparam int numBranches   = 4;
   localparam int slotBits      = 2;   // enough to number the branches

   // fixed point of the rotator
   localparam int trigBits      = 8;   // signed table value, has to hold +64 and -64
   localparam int sineShift     = 6;   // table is scaled by 2**sineShift
   localparam int quarterSteps  = 8;   // angle steps in one quadrant

   // offset taken off the winning metric when the loop asks for a normalize
   localparam logic [acsBits-1:0] normOffset = 10'd128;

   // quarter wave of 64*sin(k*pi/16), k = 0..8, the rotator mirrors it into all four quadrants
   localparam logic signed [trigBits-1:0] sineTable [0:quarterSteps] = '{
      8'sd0, 8'sd12, 8'sd24, 8'sd36, 8'sd45, 8'sd53, 8'sd59, 8'sd63, 8'sd64
   };

   // rotation constants of the two modulation indices, one per trellis branch
   localparam logic [rotConstBits-1:0] branchRot45 [0:numBranches-1] = '{
      4'd0, 4'd3, 4'd5, 4'd6
   };
   localparam logic [rotConstBits-1:0] branchRot54 [0:numBranches-1] = '{
      4'd0, 4'd2, 4'd7, 4'd1
   };

   // one matched-filter output, i above q
   typedef struct packed {
      logic [mfBits-1:0] i;
      logic [mfBits-1:0] q;
   } mfSample_t;

   typedef mfSample_t [numBranches-1:0] mfBank_t;  // index k is branch k

   // sample as the rotator sees it, before and after rotation
   typedef struct packed {
      logic [rotBits-1:0] i;
      logic [rotBits-1:0] q;
   } rotSample_t;

   typedef logic [numBranches-1:0][acsBits-1:0] metricBank_t;  // index k is branch k

   // one branch in flight through the rotator
   typedef struct packed {
      rotSample_t           sample;
      logic [angleBits-1:0] angle;  // only meaningful on the way into the rotator
      logic [slotBits-1:0]  slot;   // branch number inside the symbol
      logic                 even;   // 54 bank when set, 45 bank otherwise
      logic                 last;   // marks the final branch of the symbol
   } rotReq_t;

   // all rotated branches of one symbol side by side
   typedef struct packed {
      rotSample_t [numBranches-1:0] branch;
      logic                         even;
   } rotSet_t;

endpackage

`default_nettype wire

/* hdl/branchSerializer.sv */
`timescale 1ns/10ps
`default_nettype none

module branchSerializer (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          symEn,      // one-cycle symbol strobe
   input  logic                          symEnEven,  // picks the 54 bank, sampled with symEn
   input  logic [acsPkg::angleBits-1:0]  tilt,
   input  acsPkg::mfBank_t               mf45,
   input  acsPkg::mfBank_t               mf54,
   output acsPkg::rotReq_t               rotReq,
   output logic                          reqValid
);
   import acsPkg::*;

   mfBank_t                 bank45;    // banks held for the whole symbol
   mfBank_t                 bank54;
   logic                    evenR;
   logic [angleBits-1:0]    tiltR;     // held too, so a new tilt can't disturb the slots in flight
   logic [slotBits-1:0]     slotCnt;   // branch being handed to the rotator
   logic                    busy;      // high while slots 0 to 3 go out
   mfSample_t               branch;
   logic [rotConstBits-1:0] rotConst;

   // capture everything that describes the symbol at the strobe
   always_ff @(posedge clk) begin
      if (symEn) begin
         bank45 <= mf45;
         bank54 <= mf54;
         evenR  <= symEnEven;
         tiltR  <= tilt;
      end
   end

   // slot counter, a new strobe restarts it even if the previous symbol is still going out
   always_ff @(posedge clk) begin
      if (reset) begin
         busy    <= 1'b0;
         slotCnt <= '0;
      end else if (symEn) begin
         busy    <= 1'b1;
         slotCnt <= '0;
      end else if (busy) begin
         busy    <= (slotCnt != slotBits'(numBranches - 1));  // goes idle after slot 3
         slotCnt <= slotCnt + 1'b1;
      end
   end

   always_comb begin
      // bank and rotation constant both follow the even flag
      branch   = evenR ? bank54[slotCnt] : bank45[slotCnt];
      rotConst = evenR ? branchRot54[slotCnt] : branchRot45[slotCnt];

      // the rotator only takes the top bits, the low mf bits are dropped
      rotReq.sample.i = branch.i[mfBits-1 -: rotBits];
      rotReq.sample.q = branch.q[mfBits-1 -: rotBits];

      // 32 - tilt - 2*rot, the 5 bit width does the mod 32
      rotReq.angle = -tiltR - {rotConst, 1'b0};

      rotReq.slot = slotCnt;
      rotReq.even = evenR;
      rotReq.last = (slotCnt == slotBits'(numBranches - 1));
   end

   assign reqValid = busy;  // one branch per clock, no back-pressure

endmodule

`default_nettype wire

/* hdl/phaseRotator.sv */
`timescale 1ns/10ps
`default_nettype none

module phaseRotator (
   input  logic            clk,
   input  logic            reset,
   input  acsPkg::rotReq_t rotReq,    // sample plus angle, one branch per clock
   input  logic            reqValid,
   output acsPkg::rotReq_t rotOut,    // same fields, sample now rotated
   output logic            outValid
);
   import acsPkg::*;

   logic [1:0]                  quad;         // quadrant of the angle
   logic [angleBits-3:0]        step;         // position inside the quadrant
   logic signed [trigBits-1:0]  nearVal;      // table at step
   logic signed [trigBits-1:0]  farVal;       // table at the mirrored step
   logic signed [trigBits-1:0]  cosNext;
   logic signed [trigBits-1:0]  sinNext;
   rotReq_t                     s1Req;
   logic                        s1Valid;
   logic signed [trigBits-1:0]  cosR;
   logic signed [trigBits-1:0]  sinR;
   logic signed [rotBits+trigBits:0] iFull;  // one guard bit over the product width
   logic signed [rotBits+trigBits:0] qFull;
   rotReq_t                     s2Next;

   // stage one, fold the angle into the quarter-wave table
   always_comb begin
      quad    = rotReq.angle[angleBits-1 -: 2];
      step    = rotReq.angle[angleBits-3:0];
      nearVal = sineTable[{1'b0, step}];
      farVal  = sineTable[4'(quarterSteps) - {1'b0, step}];  // cos is sin mirrored in the quadrant
      unique case (quad)
         2'd0: begin
            sinNext = nearVal;
            cosNext = farVal;
         end
         2'd1: begin
            sinNext = farVal;   // past 90 degrees sin comes back down
            cosNext = -nearVal;
         end
         2'd2: begin
            sinNext = -nearVal;
            cosNext = -farVal;
         end
         default: begin
            sinNext = -farVal;
            cosNext = nearVal;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      s1Req <= rotReq;  // slot, even and last ride along with the sample
      cosR  <= cosNext;
      sinR  <= sinNext;
   end

   // stage two, complex multiply, then drop the table scaling
   always_comb begin
      iFull  = $signed(s1Req.sample.i) * cosR - $signed(s1Req.sample.q) * sinR;
      qFull  = $signed(s1Req.sample.i) * sinR + $signed(s1Req.sample.q) * cosR;
      s2Next = s1Req;
      s2Next.sample.i = iFull[sineShift +: rotBits];  // shift right by 6 and keep 8 bits
      s2Next.sample.q = qFull[sineShift +: rotBits];
   end

   always_ff @(posedge clk) begin
      rotOut <= s2Next;
   end

   // valid walks down the two stages with its data
   always_ff @(posedge clk) begin
      if (reset) begin
         s1Valid  <= 1'b0;
         outValid <= 1'b0;
      end else begin
         s1Valid  <= reqValid;
         outValid <= s1Valid;
      end
   end

endmodule

`default_nettype wire

/* hdl/branchCollector.sv */
`timescale 1ns/10ps
`default_nettype none

module branchCollector (
   input  logic            clk,
   input  logic            reset,
   input  acsPkg::rotReq_t rotIn,      // rotated branches, one per clock
   input  logic            inValid,
   output acsPkg::rotSet_t rotSetOut,  // whole symbol, valid only with setValid
   output logic            setValid
);
   import acsPkg::*;

   // the last branch is never stored, it goes straight through with the others
   rotSample_t held [0:numBranches-2];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int k = 0; k < numBranches - 1; k++) begin
            held[k] <= '0;  // a set seen before the first full symbol reads zero
         end
      end else if (inValid && !rotIn.last) begin
         held[rotIn.slot] <= rotIn.sample;  // slot picks the register
      end
   end

   always_comb begin
      for (int k = 0; k < numBranches - 1; k++) begin
         rotSetOut.branch[k] = held[k];
      end
      rotSetOut.branch[numBranches-1] = rotIn.sample;  // arriving branch, not yet stored
      rotSetOut.even = rotIn.even;  // even flag is the same on every branch of a symbol
   end

   // the set is complete the cycle the last branch shows up
   assign setValid = inValid && rotIn.last;

endmodule

`default_nettype wire

/* hdl/addCompareSelect.sv */
`timescale 1ns/10ps
`default_nettype none

module addCompareSelect (
   input  logic                        clk,
   input  logic                        reset,
   input  acsPkg::rotSet_t             rotSet,        // rotated branches of one symbol
   input  logic                        setValid,
   input  acsPkg::metricBank_t         accMet45,      // read on the setValid edge
   input  acsPkg::metricBank_t         accMet54,
   input  logic                        normalizeIn,   // loop asks for the offset subtraction
   output logic [acsPkg::slotBits-1:0] selOut,        // winning branch
   output logic [acsPkg::rotBits-1:0]  iOut,          // winner's rotated I
   output logic [acsPkg::rotBits-1:0]  qOut,          // winner's rotated Q
   output logic [acsPkg::acsBits-1:0]  accMetOut,
   output logic                        normalizeOut,
   output logic                        symEnOut
);
   import acsPkg::*;

   metricBank_t          metSel;                // bank chosen by the even flag
   logic [acsBits-1:0]   sum [0:numBranches-1];
   logic [slotBits-1:0]  selA;                  // winner of branches 0 and 1
   logic [slotBits-1:0]  selB;                  // winner of branches 2 and 3
   logic [slotBits-1:0]  selBest;
   logic [acsBits-1:0]   bestMetric;            // registered winning sum
   logic [acsBits:0]     offsetDiff;            // one bit wider than the metric

   // true when b beats a, so an equal pair keeps the lower index
   function automatic logic beats(input logic [acsBits-1:0] a, input logic [acsBits-1:0] b);
      return $signed(b) > $signed(a);
   endfunction

   always_comb begin
      metSel = rotSet.even ? accMet54 : accMet45;
      for (int k = 0; k < numBranches; k++) begin
         // sign-extend the rotated I, the sum wraps at the metric width
         sum[k] = {{(acsBits - rotBits){rotSet.branch[k].i[rotBits-1]}}, rotSet.branch[k].i}
                  + metSel[k];
      end
   end

   // two-level compare tree, signed throughout
   always_comb begin
      selA    = beats(sum[0], sum[1]) ? 2'd1 : 2'd0;
      selB    = beats(sum[2], sum[3]) ? 2'd3 : 2'd2;
      selBest = beats(sum[selA], sum[selB]) ? selB : selA;  // on a tie the lower pair wins
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         selOut     <= '0;
         iOut       <= '0;
         qOut       <= '0;
         bestMetric <= '0;
         symEnOut   <= 1'b0;
      end else begin
         symEnOut <= setValid;  // one pulse per finished symbol
         if (setValid) begin
            selOut     <= selBest;
            iOut       <= rotSet.branch[selBest].i;  // phase error follows the survivor
            qOut       <= rotSet.branch[selBest].q;
            bestMetric <= sum[selBest];
         end
      end
   end

   // 01 in the top bits means the positive metric is about to run out of range
   assign normalizeOut = (bestMetric[acsBits-1 -: 2] == 2'b01);

   // subtract the offset and clamp at zero, keeps the accumulators from overflowing
   // the metric is signed, so the extra bit keeps a very negative one from wrapping positive
   assign offsetDiff = {bestMetric[acsBits-1], bestMetric} - {1'b0, normOffset};
   always_comb begin
      if (!normalizeIn) begin
         accMetOut = bestMetric;
      end else if (offsetDiff[acsBits]) begin
         accMetOut = '0;  // went negative, saturate
      end else begin
         accMetOut = offsetDiff[acsBits-1:0];
      end
   end

endmodule

`default_nettype wire

/* hdl/acsMultH.sv */
`timescale 1ns/10ps
`default_nettype none

module acsMultH (
   input  logic                         clk,
   input  logic                         reset,
   input  acsPkg::mfBank_t              mf45,         // matched filter, index 4/16
   input  acsPkg::mfBank_t              mf54,         // matched filter, index 5/16
   input  acsPkg::metricBank_t          accMet45,     // must hold from symEn to symEnOut
   input  acsPkg::metricBank_t          accMet54,
   input  logic [acsPkg::angleBits-1:0] tilt,
   input  logic                         symEn,
   input  logic                         symEnEven,
   input  logic                         normalizeIn,
   output logic [acsPkg::slotBits-1:0]  selOut,
   output logic [acsPkg::rotBits-1:0]   iOut,
   output logic [acsPkg::rotBits-1:0]   qOut,
   output logic [acsPkg::acsBits-1:0]   accMetOut,
   output logic                         normalizeOut,
   output logic                         symEnOut      // seven cycles after symEn
);
   import acsPkg::*;

   rotReq_t rotReq;     // serializer to rotator
   logic    reqValid;
   rotReq_t rotOut;     // rotator to collector
   logic    outValid;
   rotSet_t rotSet;     // collector to compare stage
   logic    setValid;

   // bank capture and one branch per clock
   branchSerializer serializer (
      .clk       (clk),
      .reset     (reset),
      .symEn     (symEn),
      .symEnEven (symEnEven),
      .tilt      (tilt),
      .mf45      (mf45),
      .mf54      (mf54),
      .rotReq    (rotReq),
      .reqValid  (reqValid)
   );

   // two-cycle pipelined rotation
   phaseRotator rotator (
      .clk      (clk),
      .reset    (reset),
      .rotReq   (rotReq),
      .reqValid (reqValid),
      .rotOut   (rotOut),
      .outValid (outValid)
   );

   // serial back to parallel
   branchCollector collector (
      .clk       (clk),
      .reset     (reset),
      .rotIn     (rotOut),
      .inValid   (outValid),
      .rotSetOut (rotSet),
      .setValid  (setValid)
   );

   addCompareSelect acs (
      .clk          (clk),
      .reset        (reset),
      .rotSet       (rotSet),
      .setValid     (setValid),
      .accMet45     (accMet45),
      .accMet54     (accMet54),
      .normalizeIn  (normalizeIn),
      .selOut       (selOut),
      .iOut         (iOut),
      .qOut         (qOut),
      .accMetOut    (accMetOut),
      .normalizeOut (normalizeOut),
      .symEnOut     (symEnOut)
   );

endmodule

`default_nettype wire

/* sim/acsModel.svh */
`ifndef ACS_MODEL_SVH
`define ACS_MODEL_SVH

localparam real modelPi = 3.14159265358979;

// rotation constants restated per branch, 54 bank when even is set
function automatic int rotConstModel(input logic even, input int k);
   if (even) return (k == 0) ? 0 : (k == 1) ? 2 : (k == 2) ? 7 : 1;
   return (k == 0) ? 0 : (k == 1) ? 3 : (k == 2) ? 5 : 6;
endfunction

// angle in steps of 2*pi/32, kept positive before the mod
function automatic int angleModel(input logic [4:0] tilt, input logic even, input int k);
   return (64 - int'(tilt) - 2 * rotConstModel(even, k)) % 32;
endfunction

// 64*sin or 64*cos of the angle, rounded away from zero on halves
function automatic int trigModel(input int angle, input logic wantSin);
   real x;
   x = real'(angle) * modelPi / 16.0;
   x = wantSin ? 64.0 * $sin(x) : 64.0 * $cos(x);
   return $rtoi(x + ((x < 0.0) ? -0.5 : 0.5));
endfunction

// rotated sample as {i, q}, arithmetic shift by 6 then keep 8 bits
function automatic logic [15:0] rotateModel(input logic [7:0] i, input logic [7:0] q,
                                            input int angle);
   int c;
   int s;
   int ri;
   int rq;
   c  = trigModel(angle, 1'b0);
   s  = trigModel(angle, 1'b1);
   ri = (int'($signed(i)) * c - int'($signed(q)) * s) >>> 6;
   rq = (int'($signed(i)) * s + int'($signed(q)) * c) >>> 6;
   return {ri[7:0], rq[7:0]};
endfunction

// whole symbol, packed as {sel, i, q, best}, ties keep the lowest index
function automatic logic [27:0] expectSymbol(input mfBank_t m45, input mfBank_t m54,
                                             input metricBank_t a45, input metricBank_t a54,
                                             input logic [4:0] tilt, input logic even);
   mfSample_t   s;
   logic [15:0] rot;
   logic [9:0]  met;
   logic [9:0]  sumK;
   logic [27:0] best;
   best = '0;
   for (int k = 0; k < 4; k++) begin
      s    = even ? m54[k] : m45[k];
      met  = even ? a54[k] : a45[k];
      rot  = rotateModel(s.i[9:2], s.q[9:2], angleModel(tilt, even, k));
      sumK = 10'(int'($signed(rot[15:8])) + int'(met));
      if (k == 0 || $signed(sumK) > $signed(best[9:0])) best = {2'(k), rot, sumK};
   end
   return best;
endfunction

// metric after the optional offset, clamped at zero
function automatic logic [9:0] expectAccMet(input logic [9:0] best, input logic normIn);
   int d;
   if (!normIn) return best;
   d = int'($signed(best)) - 128;
   return (d < 0) ? 10'd0 : 10'(d);
endfunction

// 16 bit Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsrNext(input logic [15:0] s);
   return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

`endif

/* sim/acsTb.sv */
`timescale 1ns/10ps
`default_nettype none

module acsTb;
   import acsPkg::*;

   `include "acsModel.svh"

   localparam int timeoutCycles = 2000;  // the tests take a little over 400 cycles

   logic                clk;
   logic                reset;
   mfBank_t             mf45;
   mfBank_t             mf54;
   metricBank_t         accMet45;
   metricBank_t         accMet54;
   logic [4:0]          tilt;
   logic                symEn;
   logic                symEnEven;
   logic                normalizeIn;
   logic [1:0]          selOut;
   logic [7:0]          iOut;
   logic [7:0]          qOut;
   logic [9:0]          accMetOut;
   logic                normalizeOut;
   logic                symEnOut;
   logic [15:0]         lfsrState = 16'd15263;
   int                  cycleCount = 0;

   acsMultH dut (.*);

   always #4 clk = ~clk;

   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= timeoutCycles) begin
         $display("the run took too many cycles and was stopped");
         $display("sim failed");
         $fatal(1, "timeout");
      end
   end

   function automatic logic [31:0] randBits(input int n);
      logic [31:0] r;
      r = '0;
      for (int b = 0; b < n; b++) begin
         lfsrState = lfsrNext(lfsrState);  // one step per bit
         r = {r[30:0], lfsrState[0]};
      end
      return r;
   endfunction

   task automatic compare(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
      if (expected !== actual) begin
         $display("Fail %s expected %0h actual %0h", name, expected, actual);
         $display("sim failed");
         $fatal(1, "mismatch");
      end
   endtask

   // random bank, no sample truncates to -128
   task automatic randomBank(output mfBank_t bank);
      for (int k = 0; k < 4; k++) begin
         bank[k].i = 10'(randBits(10));
         bank[k].q = 10'(randBits(10));
         if (bank[k].i[9:2] == 8'h80) bank[k].i[2] = 1'b1;
         if (bank[k].q[9:2] == 8'h80) bank[k].q[2] = 1'b1;
      end
   endtask

   // one strobe, then wait for symEnOut, returns cycles from the strobe
   task automatic applySymbol(input logic even, input logic [4:0] t, output int lat);
      @(negedge clk);
      symEnEven = even;
      tilt      = t;
      symEn     = 1'b1;
      @(negedge clk);
      symEn = 1'b0;
      lat   = 1;
      while (!symEnOut && lat <= 20) begin
         @(negedge clk);
         lat++;
      end
      if (!symEnOut) begin
         $display("symEnOut never came after a symbol strobe");
         $display("sim failed");
         $fatal(1, "no result");
      end
   endtask

   task automatic checkResult(input string name, input logic [27:0] exp);
      compare({name, " sel"}, 32'(exp[27:26]), 32'(selOut));
      compare({name, " i"}, 32'(exp[25:18]), 32'(iOut));
      compare({name, " q"}, 32'(exp[17:10]), 32'(qOut));
      compare({name, " met"}, 32'(expectAccMet(exp[9:0], normalizeIn)), 32'(accMetOut));
      compare({name, " norm"}, 32'(exp[9:8] == 2'b01), 32'(normalizeOut));
   endtask

   task automatic testReset();
      repeat (3) begin
         @(negedge clk);
         compare("reset symEnOut", 32'(0), 32'(symEnOut));
         compare("reset norm", 32'(0), 32'(normalizeOut));
         compare("reset met", 32'(0), 32'(accMetOut));
         compare("reset iq", 32'(0), 32'({iOut, qOut}));
         compare("reset sel", 32'(0), 32'(selOut));
      end
   endtask

   task automatic testLatency();
      int lat;
      applySymbol(1'b0, 5'd3, lat);
      compare("latency", 32'(7), 32'(lat));
      @(negedge clk);
      compare("latency pulse width", 32'(0), 32'(symEnOut));
   endtask

   task automatic testRandom(input string name, input logic even);
      int          lat;
      logic [4:0]  t;
      logic [27:0] exp;
      for (int n = 0; n < 20; n++) begin
         randomBank(mf45);
         randomBank(mf54);
         for (int k = 0; k < 4; k++) begin
            accMet45[k] = 10'(randBits(10));
            accMet54[k] = 10'(randBits(10));
         end
         t   = 5'(randBits(5));
         exp = expectSymbol(mf45, mf54, accMet45, accMet54, t, even);
         applySymbol(even, t, lat);
         checkResult(name, exp);
      end
   endtask

   // fixed angles 0 and 8 on slot 0 of the 54 bank, plus ties
   task automatic testRigged();
      int lat;
      mf54     = '0;
      accMet54 = {10'd200, 10'd200, 10'd200, 10'd200};  // equal metrics, the samples decide
      mf54[0]  = '{i: 10'(50 * 4), q: 10'(-30 * 4)};
      applySymbol(1'b1, 5'd0, lat);  // slot 0 angle 0 is the identity
      compare("identity sel", 32'(0), 32'(selOut));
      compare("identity iq", 32'(16'h32E2), 32'({iOut, qOut}));
      mf54[0] = '{i: 10'(40 * 4), q: 10'(-20 * 4)};
      applySymbol(1'b1, 5'd24, lat);  // 90 degrees turns i into -q
      compare("quarter sel", 32'(0), 32'(selOut));
      compare("quarter iq", 32'(16'h1428), 32'({iOut, qOut}));
      mf54 = '0;
      applySymbol(1'b1, 5'd7, lat);  // every sum is 200, so all four tie
      compare("tie all lowest", 32'(0), 32'(selOut));
      accMet54[0] = 10'd100;
      applySymbol(1'b1, 5'd7, lat);
      compare("tie upper three", 32'(1), 32'(selOut));
   endtask

   task automatic testNormalize();
      int lat;
      mf45     = '0;
      accMet45 = {10'd30, 10'd20, 10'd10, 10'd300};
      applySymbol(1'b0, 5'd0, lat);
      compare("norm flag", 32'(1), 32'(normalizeOut));
      compare("norm off", 32'(300), 32'(accMetOut));
      normalizeIn = 1'b1;
      @(negedge clk);
      compare("norm subtract", 32'(172), 32'(accMetOut));
      accMet45 = {10'd30, 10'd20, 10'd10, 10'd100};
      applySymbol(1'b0, 5'd0, lat);
      compare("norm flag low", 32'(0), 32'(normalizeOut));
      compare("norm saturate", 32'(0), 32'(accMetOut));
      accMet45 = {4{10'(-450)}};  // far below zero, the difference must not wrap
      applySymbol(1'b0, 5'd0, lat);
      compare("norm saturate negative", 32'(0), 32'(accMetOut));
      normalizeIn = 1'b0;
   endtask

   task automatic testInFlight();
      logic [27:0] expQ [$];
      int          got;
      got = 0;
      for (int k = 0; k < 4; k++) begin
         accMet45[k] = 10'(randBits(10));
         accMet54[k] = 10'(randBits(10));
      end
      for (int c = 0; c < 24; c++) begin
         @(negedge clk);
         if (symEnOut) begin
            compare("in flight timing", 32'(4 * got + 7), 32'(c));
            checkResult("in flight", expQ.pop_front());
            got++;
         end
         symEn = (c % 4 == 0) && (c < 16);
         if (symEn) begin
            randomBank(mf45);
            randomBank(mf54);
            tilt      = 5'(randBits(5));
            symEnEven = randBits(1) != 0;
            expQ.push_back(expectSymbol(mf45, mf54, accMet45, accMet54, tilt, symEnEven));
         end
      end
      compare("in flight count", 32'(4), 32'(got));
   endtask

   initial begin
      clk         = 1'b0;
      reset       = 1'b1;
      mf45        = '0;
      mf54        = '0;
      accMet45    = '0;
      accMet54    = '0;
      tilt        = '0;
      symEn       = 1'b0;
      symEnEven   = 1'b0;
      normalizeIn = 1'b0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      testReset();
      testLatency();
      testRandom("bank45", 1'b0);
      testRandom("bank54", 1'b1);
      testRigged();
      testNormalize();
      testInFlight();
      $display("sim passed");
      $finish;
   end

endmodule

`default_nettype wire

/* all.f */
+incdir+sim
hdl/acsPkg.sv
hdl/branchSerializer.sv
hdl/phaseRotator.sv
hdl/branchCollector.sv
hdl/addCompareSelect.sv
hdl/acsMultH.sv
sim/acsTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= acsTb
FILELIST  ?= all.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "sim passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
